// ==== build.f ====
logic/gpio_pkg.sv
logic/gpio_bus_if.sv
logic/gpio_apb_port.sv
logic/gpio_pin_sync.sv
logic/gpio_regs.sv
logic/gpio_top.sv
verif/gpio_tb.sv

// ==== Bender.yml ====
package:
  name: apb_gpio

sources:
  # design, compile order
  - files:
      - logic/gpio_pkg.sv
      - logic/gpio_bus_if.sv
      - logic/gpio_apb_port.sv
      - logic/gpio_pin_sync.sv
      - logic/gpio_regs.sv
      - logic/gpio_top.sv
  # testbench
  - target: test
    files:
      - verif/gpio_tb.sv

// ==== verif/gpio_tb.sv ====
/* gpio testbench */

`timescale 1ns/1ps

module gpio_tb
  import gpio_pkg::*;
();

  localparam int width = 16;
  localparam int cycle_limit = 3000;  // about twice the test length

  logic                   pclk16;
  logic                   n_reset16;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [gpio_addr_w-1:0] paddr;
  logic [width-1:0]       pwdata;
  logic [width-1:0]       prdata;
  logic [width-1:0]       pin_in;
  logic [width-1:0]       tri_state_enable;
  logic [width-1:0]       interrupt;
  logic [width-1:0]       pin_out;
  logic [width-1:0]       pin_oe_n;

  // expected register contents, updated as writes complete
  logic [width-1:0] dir_m;
  logic [width-1:0] oe_m;
  logic [width-1:0] val_m;
  logic [width-1:0] rd_exp;   // expected prdata in access phase
  logic [width-1:0] irq_exp;
  logic             rd_active;  // access phase of a read
  logic             rd_check;   // compare prdata this access
  logic             irq_check;
  string            test_name;
  integer           seed = 32'haea4eac2;
  integer           cycles = 0;
  int err_pin_out = 0;
  int err_pin_oe = 0;
  int err_rdata = 0;
  int err_idle = 0;
  int err_irq = 0;

  gpio_top #(.gpio_width(width)) DUT (.*);

  initial
  begin
    pclk16 = 1'b0;
    forever #5 pclk16 = ~pclk16;  // 10 ns
  end

  // --------------------
  // checks
  // --------------------
  // enable low only for an enabled output-mode pin outside test tri-state
  function automatic logic [width-1:0] expected_oe_n(input logic [width-1:0] oe,
                                                    input logic [width-1:0] dir,
                                                    input logic [width-1:0] tse);
    logic [width-1:0] r;
    for (int b = 0; b < width; b++)
      r[b] = (oe[b] == 1'b1 && dir[b] == 1'b0 && tse[b] == 1'b0) ? 1'b0 : 1'b1;
    return r;
  endfunction

  a_pin_out : assert property (@(posedge pclk16) disable iff (!n_reset16)
    pin_out == val_m)
  else
  begin
    err_pin_out++;
    $display("[ERROR] %s: pin_out expected %h actual %h", test_name,
             $sampled(val_m), $sampled(pin_out));
  end

  a_pin_oe : assert property (@(posedge pclk16) disable iff (!n_reset16)
    pin_oe_n == expected_oe_n(oe_m, dir_m, tri_state_enable))
  else
  begin
    err_pin_oe++;
    $display("[ERROR] %s: pin_oe_n expected %h actual %h", test_name,
             expected_oe_n($sampled(oe_m), $sampled(dir_m), $sampled(tri_state_enable)),
             $sampled(pin_oe_n));
  end

  a_rdata : assert property (@(posedge pclk16) disable iff (!n_reset16)
    rd_active && rd_check |-> prdata == rd_exp)
  else
  begin
    err_rdata++;
    $display("[ERROR] %s: prdata expected %h actual %h", test_name,
             $sampled(rd_exp), $sampled(prdata));
  end

  // bus sits at zero outside a read access phase
  a_rd_idle : assert property (@(posedge pclk16) disable iff (!n_reset16)
    !rd_active |-> prdata == '0)
  else
  begin
    err_idle++;
    $display("[ERROR] %s: idle prdata expected %h actual %h", test_name,
             {width{1'b0}}, $sampled(prdata));
  end

  a_irq : assert property (@(posedge pclk16) disable iff (!n_reset16)
    irq_check |-> interrupt == irq_exp)
  else
  begin
    err_irq++;
    $display("[ERROR] %s: interrupt expected %h actual %h", test_name,
             $sampled(irq_exp), $sampled(interrupt));
  end

  // --------------------
  // bus tasks
  // --------------------
  task automatic apb_write(input logic [gpio_addr_w-1:0] addr, input logic [width-1:0] data);
    psel = 1'b1;  // setup
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge pclk16);
    penable = 1'b1;  // access, commits at next rise
    @(negedge pclk16);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    case (addr)
      gpr_direction_mode : dir_m = data;
      gpr_output_enable  : oe_m = data;
      gpr_output_value   : val_m = data;
      default            : ;
    endcase
  endtask

  task automatic apb_read(input logic [gpio_addr_w-1:0] addr, input logic [width-1:0] exp,
                          input logic check);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge pclk16);
    penable = 1'b1;
    rd_active = 1'b1;
    rd_exp = exp;
    rd_check = check;
    @(negedge pclk16);
    psel = 1'b0;
    penable = 1'b0;
    rd_active = 1'b0;
    rd_check = 1'b0;
  endtask

  task automatic expect_irq(input logic [width-1:0] exp);
    irq_exp = exp;
    irq_check = 1'b1;
    @(negedge pclk16);
    irq_check = 1'b0;
  endtask

  // word offset that no register decodes
  function automatic logic [gpio_addr_w-1:0] pick_unmapped(input logic [31:0] r);
    logic [gpio_addr_w-1:0] a;
    a = {r[5:2], 2'b00};
    if (a == gpr_direction_mode || a == gpr_output_enable || a == gpr_output_value ||
        a == gpr_input_value || a == gpr_int_status)
      a = 6'h00;
    return a;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  initial
  begin
    logic [width-1:0] d;
    logic [width-1:0] old_pins;
    logic [width-1:0] exp;
    n_reset16 = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pin_in = '0;
    tri_state_enable = '0;
    dir_m = '0;
    oe_m = '0;
    val_m = '0;
    rd_exp = '0;
    irq_exp = '0;
    rd_active = 1'b0;
    rd_check = 1'b0;
    irq_check = 1'b0;
    test_name = "reset";
    repeat (4) @(negedge pclk16);
    n_reset16 = 1'b1;
    expect_irq('0);  // nothing pending out of reset
    apb_read(gpr_direction_mode, '0, 1'b1);
    apb_read(gpr_output_enable, '0, 1'b1);
    apb_read(gpr_output_value, '0, 1'b1);
    apb_read(gpr_input_value, '0, 1'b1);
    apb_read(gpr_int_status, '0, 1'b1);

    test_name = "readback";
    pin_in = $random(seed);  // nonzero pins for the unmapped reads
    repeat (3) @(negedge pclk16);
    for (int i = 0; i < 30; i++)
    begin
      d = $random(seed);
      apb_write(gpr_direction_mode, d);
      apb_read(gpr_direction_mode, d, 1'b1);
      d = $random(seed);
      apb_write(gpr_output_enable, d);
      apb_read(gpr_output_enable, d, 1'b1);
      d = $random(seed);
      apb_write(gpr_output_value, d);
      apb_read(gpr_output_value, d, 1'b1);
      apb_read(pick_unmapped($random(seed)), pin_in, 1'b1);  // pins steady here
    end

    test_name = "pin_drive";
    for (int i = 0; i < 30; i++)
    begin
      apb_write(gpr_direction_mode, $random(seed) & $random(seed));  // mostly outputs
      apb_write(gpr_output_enable, $random(seed));
      apb_write(gpr_output_value, $random(seed));
      tri_state_enable = $random(seed) & $random(seed) & $random(seed);
      @(negedge pclk16);
    end
    tri_state_enable = '0;

    test_name = "input_path";
    for (int i = 0; i < 20; i++)
    begin
      pin_in = $random(seed);
      repeat (3) @(negedge pclk16);  // two sync stages plus latch
      apb_read(gpr_input_value, pin_in, 1'b1);
    end

    test_name = "interrupt";
    for (int i = 0; i < 20; i++)
    begin
      d = $random(seed) | 1;  // at least one input pin
      apb_write(gpr_direction_mode, d);
      old_pins = $random(seed);
      pin_in = old_pins;
      repeat (4) @(negedge pclk16);
      apb_read(gpr_int_status, '0, 1'b0);  // flush older edges
      expect_irq('0);
      pin_in = $random(seed);
      repeat (4) @(negedge pclk16);
      exp = pin_in & ~old_pins & d;  // rising, input mode only
      expect_irq(exp);
      apb_read(gpr_int_status, exp, 1'b1);
      expect_irq('0);  // cleared by the read
    end

    repeat (2) @(negedge pclk16);
    $display("errors: pin_out %0d, pin_oe_n %0d, rdata %0d, idle %0d, interrupt %0d",
             err_pin_out, err_pin_oe, err_rdata, err_idle, err_irq);
    if (err_pin_out + err_pin_oe + err_rdata + err_idle + err_irq == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // --------------------
  // watchdog
  // --------------------
  initial
  begin
    while (cycles < cycle_limit)
    begin
      @(posedge pclk16);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

endmodule : gpio_tb

// ==== logic/gpio_top.sv ====
/* apb gpio top level */

`timescale 1ns/1ps

module gpio_top
  import gpio_pkg::*;
#(
  parameter int gpio_width = 16  // pin count, 32 max
) (
  input  logic                   pclk16,
  input  logic                   n_reset16,
  // apb slave
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [gpio_addr_w-1:0] paddr,
  input  logic [gpio_width-1:0]  pwdata,
  output logic [gpio_width-1:0]  prdata,
  // pads
  input  logic [gpio_width-1:0]  pin_in,
  input  logic [gpio_width-1:0]  tri_state_enable,
  output logic [gpio_width-1:0]  interrupt,
  output logic [gpio_width-1:0]  pin_out,
  output logic [gpio_width-1:0]  pin_oe_n
);

  gpio_bus_if #(.gpio_width(gpio_width)) bus ();  // port -> regs

  logic [gpio_width-1:0] input_value;  // sync -> regs
  logic [gpio_width-1:0] int_event;
  logic [gpio_width-1:0] rdata;

  // --------------------
  // stage 1, bus
  // --------------------
  gpio_apb_port #(.gpio_width(gpio_width)) u_apb_port (
    .pclk16    (pclk16),
    .n_reset16 (n_reset16),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .bus       (bus.port)
  );

  // --------------------
  // stage 2, pins in
  // --------------------
  gpio_pin_sync #(.gpio_width(gpio_width)) u_pin_sync (
    .pclk16      (pclk16),
    .n_reset16   (n_reset16),
    .pin_in      (pin_in),
    .input_value (input_value),
    .int_event   (int_event)
  );

  // --------------------
  // stage 3, registers
  // --------------------
  gpio_regs #(.gpio_width(gpio_width)) u_regs (
    .pclk16           (pclk16),
    .n_reset16        (n_reset16),
    .bus              (bus.regs),
    .input_value      (input_value),
    .int_event        (int_event),
    .tri_state_enable (tri_state_enable),
    .rdata            (rdata),
    .interrupt        (interrupt),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n)
  );

  assign prdata = rdata;  // already registered in the block

endmodule : gpio_top

// ==== logic/gpio_regs.sv ====
/* gpio register block */

`timescale 1ns/1ps

module gpio_regs
  import gpio_pkg::*;
#(
  parameter int gpio_width = 16
) (
  input  logic                  pclk16,
  input  logic                  n_reset16,
  gpio_bus_if.regs              bus,
  input  logic [gpio_width-1:0] input_value,       // synchronized pins
  input  logic [gpio_width-1:0] int_event,         // 0->1 seen on pin
  input  logic [gpio_width-1:0] tri_state_enable,  // test mode, forces oe off
  output logic [gpio_width-1:0] rdata,             // registered read data
  output logic [gpio_width-1:0] interrupt,         // sticky status out
  output logic [gpio_width-1:0] pin_out,           // pad output value
  output logic [gpio_width-1:0] pin_oe_n           // pad enable, active low
);

  // --------------------
  // register storage
  // --------------------
  logic [gpio_width-1:0] direction_mode;  // 1 = input, 0 = output
  logic [gpio_width-1:0] output_enable;   // 1 = drive pad
  logic [gpio_width-1:0] output_value;    // level to drive
  logic [gpio_width-1:0] int_status;      // sticky rising-edge flags

  logic [gpio_width-1:0] int_trigger;     // edges on input-mode pins
  logic [gpio_width-1:0] status_clear;    // all ones on a status read
  logic [gpio_width-1:0] rdata_d;         // read mux output
  logic [gpio_width-1:0] rdata_q;

  // address hits
  logic hit_direction;
  logic hit_enable;
  logic hit_value;
  logic hit_status;

  assign hit_direction = (bus.addr == gpr_direction_mode);
  assign hit_enable    = (bus.addr == gpr_output_enable);
  assign hit_value     = (bus.addr == gpr_output_value);
  assign hit_status    = (bus.addr == gpr_int_status);

  // --------------------
  // rw registers
  // --------------------
  always_ff @(posedge pclk16 or negedge n_reset16)
  begin
    if (!n_reset16)
    begin
      direction_mode <= gprv_direction_mode[gpio_width-1:0];
      output_enable  <= gprv_output_enable[gpio_width-1:0];
      output_value   <= gprv_output_value[gpio_width-1:0];
    end
    else if (bus.write)
    begin
      if (hit_direction)
      begin
        direction_mode <= bus.wdata;
      end
      if (hit_enable)
      begin
        output_enable <= bus.wdata;
      end
      if (hit_value)
      begin
        output_value <= bus.wdata;
      end
    end
  end

  // --------------------
  // interrupt status
  // --------------------
  // output-mode pins never flag
  assign int_trigger  = direction_mode & int_event;
  assign status_clear = {gpio_width{bus.read & hit_status}};  // clear on read

  always_ff @(posedge pclk16 or negedge n_reset16)
  begin
    if (!n_reset16)
    begin
      int_status <= gprv_int_status[gpio_width-1:0];
    end
    else
    begin
      // a new edge in the same cycle as the clearing read survives
      int_status <= (int_status & ~status_clear) | int_trigger;
    end
  end

  assign interrupt = int_status;

  // --------------------
  // read path
  // --------------------
  always_comb
  begin
    case (bus.addr)
      gpr_direction_mode : rdata_d = direction_mode;
      gpr_output_enable  : rdata_d = output_enable;
      gpr_output_value   : rdata_d = output_value;
      gpr_int_status     : rdata_d = int_status;   // old value, clears same edge
      gpr_input_value    : rdata_d = input_value;
      default            : rdata_d = input_value;  // unmapped offsets
    endcase
  end

  always_ff @(posedge pclk16 or negedge n_reset16)
  begin
    if (!n_reset16)
    begin
      rdata_q <= '0;
    end
    else if (bus.read)
    begin
      rdata_q <= rdata_d;  // captured in setup, held through access
    end
    else
    begin
      rdata_q <= '0;  // bus idles at zero
    end
  end

  assign rdata = rdata_q;

  // --------------------
  // pad drive
  // --------------------
  assign pin_out  = output_value;
  // drive only when enabled, in output mode and not in test tri-state
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

  // --------------------
  // checks
  // --------------------
  a_no_read_write : assert property (
    @(posedge pclk16) disable iff (!n_reset16)
    !(bus.read && bus.write)
  ) else $error("regs: read and write strobes together");

  // a status bit only rises on an input-mode pin whose input value
  // rose at the same edge
  a_irq_input_only : assert property (
    @(posedge pclk16) disable iff (!n_reset16)
    ((int_status & ~$past(int_status)
      & ~($past(direction_mode) & input_value & ~$past(input_value))) == '0)
  ) else $error("regs: interrupt rose without a rising edge on an input-mode pin");

endmodule : gpio_regs

// ==== logic/gpio_pin_sync.sv ====
/* pin input synchronizer */

`timescale 1ns/1ps

module gpio_pin_sync
  import gpio_pkg::*;
#(
  parameter int gpio_width = 16
) (
  input  logic                  pclk16,
  input  logic                  n_reset16,
  input  logic [gpio_width-1:0] pin_in,       // async pad inputs
  output logic [gpio_width-1:0] input_value,  // stage three latch
  output logic [gpio_width-1:0] int_event     // rising edge seen
);

  // --------------------
  // metastability chain
  // --------------------
  logic [gpio_width-1:0] sync_one;   // first flop, may go metastable
  logic [gpio_width-1:0] sync_two;   // settled copy
  logic [gpio_width-1:0] in_latch;   // value seen by the register block

  always_ff @(posedge pclk16 or negedge n_reset16)
  begin
    if (!n_reset16)
    begin
      sync_one <= '0;
      sync_two <= '0;
      in_latch <= gprv_input_value[gpio_width-1:0];
    end
    else
    begin
      sync_one <= pin_in;    // pad edge N lands here
      sync_two <= sync_one;  // N+1
      in_latch <= sync_two;  // N+2, visible on input_value
    end
  end

  assign input_value = in_latch;

  // --------------------
  // edge detect
  // --------------------
  // new value is 1 and latch still holds 0, i.e. a 0->1 change on its way in.
  // the event is high in the cycle before the latch updates, so a status
  // bit set from it lines up with the input_value change
  assign int_event = sync_two & ~in_latch;

endmodule : gpio_pin_sync

// ==== logic/gpio_apb_port.sv ====
/* apb slave port */

`timescale 1ns/1ps

module gpio_apb_port
  import gpio_pkg::*;
#(
  parameter int gpio_width = 16
) (
  input  logic                   pclk16,
  input  logic                   n_reset16,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [gpio_addr_w-1:0] paddr,
  input  logic [gpio_width-1:0]  pwdata,
  gpio_bus_if.port               bus
);

  // --------------------
  // phase decode
  // --------------------
  logic setup_phase;   // psel up, penable not yet
  logic access_phase;  // both up
  logic setup_q;       // previous cycle was a setup phase

  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  // read fires early so rdata is ready for the access phase
  assign bus.read  = setup_phase & ~pwrite;
  // write commits at the end of access
  assign bus.write = access_phase & pwrite;

  // address and data pass straight on, no staging
  assign bus.addr  = paddr;
  assign bus.wdata = pwdata;

  // --------------------
  // phase tracking
  // --------------------
  always_ff @(posedge pclk16 or negedge n_reset16)
  begin
    if (!n_reset16)
    begin
      setup_q <= 1'b0;
    end
    else
    begin
      setup_q <= setup_phase;  // one bit of history is enough
    end
  end

  // --------------------
  // protocol checks
  // --------------------
  // penable must only come up inside a selected transfer
  a_penable_needs_psel : assert property (
    @(posedge pclk16) disable iff (!n_reset16)
    $rose(penable) |-> psel
  ) else $error("apb: penable rose without psel");

  // every access phase is preceded by exactly one setup cycle
  a_access_after_setup : assert property (
    @(posedge pclk16) disable iff (!n_reset16)
    access_phase |-> setup_q
  ) else $error("apb: access phase without setup phase");

  // setup is never held, next cycle must be access
  a_setup_then_access : assert property (
    @(posedge pclk16) disable iff (!n_reset16)
    setup_phase |=> access_phase
  ) else $error("apb: setup phase not followed by access");

endmodule : gpio_apb_port

// ==== logic/gpio_bus_if.sv ====
/* gpio register bus */

`timescale 1ns/1ps

interface gpio_bus_if
  import gpio_pkg::*;
#(
  parameter int gpio_width = 16  // pin count, sets wdata width
) ();

  logic                   read;   // one-cycle read strobe
  logic                   write;  // one-cycle write strobe
  logic [gpio_addr_w-1:0] addr;   // register offset
  logic [gpio_width-1:0]  wdata;  // write payload

  // bus side, drives the strobes
  modport port (
    output read,
    output write,
    output addr,
    output wdata
  );

  // register side
  modport regs (
    input read,
    input write,
    input addr,
    input wdata
  );

endinterface : gpio_bus_if

// ==== logic/gpio_pkg.sv ====
/* gpio shared constants */

package gpio_pkg;

  // --------------------
  // bus geometry
  // --------------------
  parameter int gpio_addr_w = 6;  // apb paddr width, byte offsets

  // --------------------
  // register offsets
  // --------------------
  // direction bit 1 = input, 0 = output
  parameter logic [gpio_addr_w-1:0] gpr_direction_mode = 6'h04;
  parameter logic [gpio_addr_w-1:0] gpr_output_enable  = 6'h08;  // oe per pin
  parameter logic [gpio_addr_w-1:0] gpr_output_value   = 6'h0C;  // driven value
  parameter logic [gpio_addr_w-1:0] gpr_input_value    = 6'h10;  // read only
  parameter logic [gpio_addr_w-1:0] gpr_int_status     = 6'h20;  // read only, clear on read

  // --------------------
  // reset values
  // --------------------
  // full 32-bit values, each user slices down to its pin count
  parameter logic [31:0] gprv_direction_mode = 32'h0000_0000;  // all outputs
  parameter logic [31:0] gprv_output_enable  = 32'h0000_0000;  // all tri-stated
  parameter logic [31:0] gprv_output_value   = 32'h0000_0000;  // drive zero
  parameter logic [31:0] gprv_input_value    = 32'h0000_0000;  // latch empty
  parameter logic [31:0] gprv_int_status     = 32'h0000_0000;  // no pending irq

endpackage : gpio_pkg
